/* verilog/opreq_pkg.sv */
/*
  Shared widths, enums and packed structs of the operand request stage.
  One lane with 64-bit VRF words and up to 8 instructions in flight.
*/
`default_nettype none

package opreq_pkg;

  localparam int unsigned ElenBits        = 64;
  localparam int unsigned NrOperandQueues = 3;
  localparam int unsigned NrWriters       = 2;
  localparam int unsigned NrVInsn         = 8;
  localparam int unsigned VAddrWidth      = 8;
  localparam int unsigned VRegWords       = 8;
  localparam int unsigned VlWidth         = 10;

  // Bank masters: operand queues first, then the writers
  localparam int unsigned NrMasters = NrOperandQueues + NrWriters;

  typedef logic [ElenBits-1:0]        elen_t;
  typedef logic [ElenBits/8-1:0]      strb_t;
  typedef logic [VAddrWidth-1:0]      vaddr_t;
  typedef logic [VlWidth-1:0]         vlen_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // A word holds (8 >> eew) elements
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    OPQ_ALU_A = 2'd0,
    OPQ_ALU_B = 2'd1,
    OPQ_STORE = 2'd2
  } opqueue_e;

  typedef enum logic {
    WR_ALU = 1'b0,
    WR_LDU = 1'b1
  } writer_e;

  typedef struct packed {
    logic [4:0]         vs;
    vew_e               eew;
    vlen_t              vl;
    vlen_t              vstart;
    logic [NrVInsn-1:0] hazard;
  } operand_request_t;

  typedef struct packed {
    vew_e  eew;
    vlen_t vl;
  } operand_queue_cmd_t;

  typedef struct packed {
    logic   req;
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_req_t;

  // Bank access; addr is the address inside the bank
  typedef struct packed {
    vaddr_t   addr;
    logic     wen;
    elen_t    wdata;
    strb_t    be;
    opqueue_e opqueue;
  } vrf_req_t;

  // Running state of one operand requester
  typedef struct packed {
    vaddr_t             addr;
    vlen_t              len;
    vew_e               vew;
    logic [NrVInsn-1:0] hazard;
  } requester_state_t;

endpackage

`default_nettype wire

/* verilog/request_decoder.sv */
/*
  Turns an operand request command into the start state of a requester.
  The start word address wraps at 8 bits for large vs and vstart.
*/
`timescale 1ns/1ns
`default_nettype none

module request_decoder (
  input  opreq_pkg::operand_request_t   operand_request_i,
  output opreq_pkg::requester_state_t   requester_init_o,
  output opreq_pkg::operand_queue_cmd_t queue_cmd_o
);

  import opreq_pkg::*;

  // log2 of the elements per word at the narrowest width
  localparam int unsigned MaxShift = $clog2(ElenBits / 8);

  logic [2:0] vstart_shift;
  vaddr_t     reg_base;
  vlen_t      vstart_words;

  // Elements per word is 8 >> eew, so divide vstart by that
  assign vstart_shift = 3'(MaxShift) - {1'b0, operand_request_i.eew};
  assign vstart_words = operand_request_i.vstart >> vstart_shift;

  // Each vector register takes VRegWords consecutive words
  assign reg_base = vaddr_t'(operand_request_i.vs * VRegWords);

  assign requester_init_o = '{
    addr:   reg_base + vaddr_t'(vstart_words),
    len:    operand_request_i.vl,
    vew:    operand_request_i.eew,
    hazard: operand_request_i.hazard
  };

  assign queue_cmd_o = '{
    eew: operand_request_i.eew,
    vl:  operand_request_i.vl
  };

endmodule

`default_nettype wire

/* verilog/operand_requester.sv */
/*
  Reads one VRF word per grant for one operand queue, in address order.
  Grants arrive in the request cycle. A command with vl of 0 is taken
  and reads nothing.
*/
`timescale 1ns/1ns
`default_nettype none

module operand_requester #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     request_valid_i,
  output logic                                     request_ready_o,
  input  opreq_pkg::requester_state_t              requester_init_i,
  input  opreq_pkg::operand_queue_cmd_t            queue_cmd_i,
  output opreq_pkg::operand_queue_cmd_t            queue_cmd_o,
  output logic                                     queue_cmd_valid_o,
  input  logic                                     queue_ready_i,
  input  logic [opreq_pkg::NrVInsn-1:0]            vinsn_running_i,
  input  logic [opreq_pkg::NrVInsn-1:0]            vinsn_written_i,
  output logic [NrBanks-1:0]                       bank_req_o,
  output opreq_pkg::vrf_req_t                      payload_o,
  input  logic [NrBanks-1:0]                       bank_gnt_i,
  output logic                                     issued_o,
  input  opreq_pkg::opqueue_e                      opqueue_i
);

  import opreq_pkg::*;

  localparam int unsigned BankW = $clog2(NrBanks);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e           state_d, state_q;
  requester_state_t req_d, req_q;

  logic               stall;
  logic               granted;
  logic [BankW-1:0]   bank_idx;
  vlen_t              elems_per_word;

  // Hold off while a hazard instruction has not written in the last cycle
  assign stall          = |(req_q.hazard & ~vinsn_written_i);
  assign granted        = |bank_gnt_i;
  assign issued_o       = granted;
  assign bank_idx       = req_q.addr[BankW-1:0];
  assign elems_per_word = vlen_t'(ElenBits / 8) >> req_q.vew;

  always_comb begin
    state_d           = state_q;
    req_d             = req_q;
    request_ready_o   = 1'b0;
    queue_cmd_o       = '0;
    queue_cmd_valid_o = 1'b0;
    bank_req_o        = '0;
    payload_o         = '0;

    case (state_q)
      IDLE: begin
        if (request_valid_i) begin
          request_ready_o   = 1'b1;
          queue_cmd_o       = queue_cmd_i;
          queue_cmd_valid_o = 1'b1;
          req_d             = requester_init_i;
          state_d           = (requester_init_i.len != '0) ? REQUESTING : IDLE;
        end
      end

      REQUESTING: begin
        // Everything is held while the queue is full
        if (queue_ready_i) begin
          bank_req_o[bank_idx] = !stall;
          payload_o = '{
            addr:    vaddr_t'(req_q.addr >> BankW),
            wen:     1'b0,
            wdata:   '0,
            be:      '0,
            opqueue: opqueue_i
          };

          if (granted) begin
            req_d.addr = req_q.addr + 1'b1;
            // Last word may be partly used
            if (req_q.len < elems_per_word) begin
              req_d.len = '0;
            end else begin
              req_d.len = req_q.len - elems_per_word;
            end
          end

          // Finished instructions release their hazard
          req_d.hazard = req_q.hazard & vinsn_running_i;

          if (req_d.len == '0) begin
            state_d = IDLE;
          end
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      req_q   <= '0;
    end else begin
      state_q <= state_d;
      req_q   <= req_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/result_collector.sv */
/*
  Routes ALU and load-unit writes to their banks and returns the grants.
  Written flags show the IDs granted in the previous cycle only.
*/
`timescale 1ns/1ns
`default_nettype none

module result_collector #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  opreq_pkg::result_req_t [opreq_pkg::NrWriters-1:0]       result_i,
  output logic [opreq_pkg::NrWriters-1:0]                         result_gnt_o,
  output logic [opreq_pkg::NrWriters-1:0][NrBanks-1:0]            bank_req_o,
  output opreq_pkg::vrf_req_t [opreq_pkg::NrWriters-1:0]          payload_o,
  input  logic [opreq_pkg::NrWriters-1:0][NrBanks-1:0]            bank_gnt_i,
  output logic [opreq_pkg::NrVInsn-1:0]                           vinsn_written_o
);

  import opreq_pkg::*;

  localparam int unsigned BankW = $clog2(NrBanks);

  logic [NrVInsn-1:0] written_d;

  for (genvar w = 0; w < NrWriters; w++) begin : gen_writer
    always_comb begin
      bank_req_o[w] = '0;
      // Low address bits pick the bank
      bank_req_o[w][result_i[w].addr[BankW-1:0]] = result_i[w].req;
    end

    assign payload_o[w] = '{
      addr:    vaddr_t'(result_i[w].addr >> BankW),
      wen:     1'b1,
      wdata:   result_i[w].wdata,
      be:      result_i[w].be,
      opqueue: OPQ_ALU_A
    };

    assign result_gnt_o[w] = |bank_gnt_i[w];
  end

  // Which instructions wrote a result this cycle
  always_comb begin
    written_d = '0;
    for (int w = 0; w < NrWriters; w++) begin
      if (result_gnt_o[w]) begin
        written_d[result_i[w].id] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vinsn_written_o <= '0;
    end else begin
      vinsn_written_o <= written_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/bank_arbiter.sv */
/*
  Round-robin arbiter of one VRF bank over queue and writer masters.
  The bank takes every request at once, so a grant never waits.
*/
`timescale 1ns/1ns
`default_nettype none

module bank_arbiter (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic [opreq_pkg::NrMasters-1:0]                    req_i,
  input  opreq_pkg::vrf_req_t [opreq_pkg::NrMasters-1:0]     payload_i,
  output logic [opreq_pkg::NrMasters-1:0]                    gnt_o,
  output logic                                               vrf_req_o,
  output opreq_pkg::vrf_req_t                                vrf_o
);

  import opreq_pkg::*;

  localparam int unsigned IdxW = $clog2(NrMasters);

  logic [IdxW-1:0] ptr_d, ptr_q;
  logic [IdxW-1:0] sel;
  logic            found;

  // Search from the pointer upwards, wrapping at the last master
  always_comb begin : p_search
    logic [IdxW-1:0] cand;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 0; i < NrMasters; i++) begin
      cand = IdxW'((ptr_q + i) % NrMasters);
      if (!found && req_i[cand]) begin
        found = 1'b1;
        sel   = cand;
      end
    end
  end

  always_comb begin
    gnt_o      = '0;
    gnt_o[sel] = found;
  end

  // Immediate acknowledge
  assign vrf_req_o = found;
  assign vrf_o     = found ? payload_i[sel] : '0;

  // Winner gets lowest priority next time
  assign ptr_d = (sel == IdxW'(NrMasters - 1)) ? '0 : sel + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/operand_request_stage.sv */
/*
  Operand request stage of one vector lane with the VRF bank arbiters.
  NrBanks must be a power of two from 2 to 8.
*/
`timescale 1ns/1ns
`default_nettype none

module operand_request_stage #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  opreq_pkg::operand_request_t [opreq_pkg::NrOperandQueues-1:0]   operand_request_i,
  input  logic [opreq_pkg::NrOperandQueues-1:0]                        operand_request_valid_i,
  output logic [opreq_pkg::NrOperandQueues-1:0]                        operand_request_ready_o,
  input  logic [opreq_pkg::NrOperandQueues-1:0]                        operand_queue_ready_i,
  input  logic [opreq_pkg::NrVInsn-1:0]                                vinsn_running_i,
  output opreq_pkg::operand_queue_cmd_t [opreq_pkg::NrOperandQueues-1:0] operand_queue_cmd_o,
  output logic [opreq_pkg::NrOperandQueues-1:0]                        operand_queue_cmd_valid_o,
  output logic [opreq_pkg::NrOperandQueues-1:0]                        operand_issued_o,
  input  opreq_pkg::result_req_t [opreq_pkg::NrWriters-1:0]            result_i,
  output logic [opreq_pkg::NrWriters-1:0]                              result_gnt_o,
  output logic [NrBanks-1:0]                                           vrf_req_o,
  output opreq_pkg::vrf_req_t [NrBanks-1:0]                            vrf_o
);

  import opreq_pkg::*;

  requester_state_t   [NrOperandQueues-1:0] requester_init;
  operand_queue_cmd_t [NrOperandQueues-1:0] decoded_cmd;
  logic [NrVInsn-1:0]                       vinsn_written;

  // Master-major as driven by the requesters and the collector
  logic     [NrMasters-1:0][NrBanks-1:0] master_req;
  logic     [NrMasters-1:0][NrBanks-1:0] master_gnt;
  vrf_req_t [NrMasters-1:0]              master_payload;

  // Bank-major as seen by the arbiters
  logic [NrBanks-1:0][NrMasters-1:0] bank_req;
  logic [NrBanks-1:0][NrMasters-1:0] bank_gnt;

  for (genvar q = 0; q < NrOperandQueues; q++) begin : gen_queue
    request_decoder i_request_decoder (
      .operand_request_i(operand_request_i[q]),
      .requester_init_o (requester_init[q]),
      .queue_cmd_o      (decoded_cmd[q])
    );

    operand_requester #(
      .NrBanks(NrBanks)
    ) i_operand_requester (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .request_valid_i  (operand_request_valid_i[q]),
      .request_ready_o  (operand_request_ready_o[q]),
      .requester_init_i (requester_init[q]),
      .queue_cmd_i      (decoded_cmd[q]),
      .queue_cmd_o      (operand_queue_cmd_o[q]),
      .queue_cmd_valid_o(operand_queue_cmd_valid_o[q]),
      .queue_ready_i    (operand_queue_ready_i[q]),
      .vinsn_running_i  (vinsn_running_i),
      .vinsn_written_i  (vinsn_written),
      .bank_req_o       (master_req[q]),
      .payload_o        (master_payload[q]),
      .bank_gnt_i       (master_gnt[q]),
      .issued_o         (operand_issued_o[q]),
      .opqueue_i        (opqueue_e'(q))
    );
  end

  // Writers follow the queues in master order
  result_collector #(
    .NrBanks(NrBanks)
  ) i_result_collector (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .result_i       (result_i),
    .result_gnt_o   (result_gnt_o),
    .bank_req_o     (master_req[NrMasters-1:NrOperandQueues]),
    .payload_o      (master_payload[NrMasters-1:NrOperandQueues]),
    .bank_gnt_i     (master_gnt[NrMasters-1:NrOperandQueues]),
    .vinsn_written_o(vinsn_written)
  );

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    for (genvar m = 0; m < NrMasters; m++) begin : gen_transpose
      assign bank_req[b][m]   = master_req[m][b];
      assign master_gnt[m][b] = bank_gnt[b][m];
    end

    bank_arbiter i_bank_arbiter (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .req_i    (bank_req[b]),
      .payload_i(master_payload),
      .gnt_o    (bank_gnt[b]),
      .vrf_req_o(vrf_req_o[b]),
      .vrf_o    (vrf_o[b])
    );
  end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
/*
  Free-running testbench clock with an active-low reset at start-up.
  Reset is released on a falling edge after ResetCycles periods.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    #(PeriodNs * ResetCycles);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* dv/operand_request_checker.sv */
/*
  Assertions bound into the operand request stage.
  Grants are checked per bank on the internal bank-major grant matrix.
*/
`timescale 1ns/1ns
`default_nettype none

module operand_request_checker #(
  parameter int unsigned NrBanks = 4
) (
  input logic                                                   clk_i,
  input logic                                                   rst_ni,
  input logic [opreq_pkg::NrOperandQueues-1:0]                  operand_request_valid_i,
  input logic [opreq_pkg::NrOperandQueues-1:0]                  operand_request_ready_o,
  input logic [opreq_pkg::NrOperandQueues-1:0]                  operand_queue_cmd_valid_o,
  input logic [opreq_pkg::NrOperandQueues-1:0]                  operand_queue_ready_i,
  input logic [opreq_pkg::NrOperandQueues-1:0]                  operand_issued_o,
  input logic [NrBanks-1:0][opreq_pkg::NrMasters-1:0]           bank_gnt
);

  import opreq_pkg::*;

  // At most one master per bank and cycle
  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_gnt[b]))
      else $error("bank %0d granted more than one master", b);
  end

  // Requesters are idle while reset is held
  assert property (@(posedge clk_i) !rst_ni |-> operand_issued_o == '0)
    else $error("operand issued during reset");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (operand_request_ready_o & ~operand_request_valid_i) == '0)
    else $error("command ready without valid");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   operand_queue_cmd_valid_o == operand_request_ready_o)
    else $error("queue command valid differs from command ready");

  // A full queue stops all reads of its requester
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (operand_issued_o & ~operand_queue_ready_i) == '0)
    else $error("read issued while operand queue not ready");

endmodule

`default_nettype wire

/* dv/tb_operand_request_stage.sv */
/*
  Testbench of the operand request stage with four VRF banks.
  Expected bank words come from a reference model of the address rules.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_operand_request_stage;

  import opreq_pkg::*;

  localparam int unsigned NrBanks   = 4;
  localparam int unsigned PeriodNs  = 100;
  localparam int unsigned NrCmds    = 7;
  localparam int unsigned MaxWords  = 32;
  localparam int unsigned TimeoutNs = (NrCmds * MaxWords * 2 + 300) * PeriodNs;

  typedef struct packed {
    logic [7:0] bank;
    vaddr_t     addr;
    opqueue_e   opq;
  } exp_word_t;

  typedef struct packed {
    logic [7:0] bank;
    vrf_req_t   req;
  } exp_write_t;

  logic clk;
  logic rst_n;

  operand_request_t   [NrOperandQueues-1:0] operand_request;
  logic               [NrOperandQueues-1:0] request_valid;
  logic               [NrOperandQueues-1:0] request_ready;
  logic               [NrOperandQueues-1:0] queue_ready;
  logic               [NrVInsn-1:0]         vinsn_running;
  operand_queue_cmd_t [NrOperandQueues-1:0] queue_cmd;
  logic               [NrOperandQueues-1:0] queue_cmd_valid;
  logic               [NrOperandQueues-1:0] issued;
  result_req_t        [NrWriters-1:0]       result;
  logic               [NrWriters-1:0]       result_gnt;
  logic               [NrBanks-1:0]         vrf_req;
  vrf_req_t           [NrBanks-1:0]         vrf;

  exp_word_t          exp_rd [NrOperandQueues][$];
  exp_write_t         exp_wr [$];
  operand_request_t   pending_cmd [NrOperandQueues];
  logic [31:0]        lfsr = 32'd93;
  int                 value_errs = 0;
  int                 other_errs = 0;

  tb_clock_gen #(
    .PeriodNs   (PeriodNs),
    .ResetCycles(4)
  ) i_tb_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  operand_request_stage #(
    .NrBanks(NrBanks)
  ) i_operand_request_stage (
    .clk_i                    (clk),
    .rst_ni                   (rst_n),
    .operand_request_i        (operand_request),
    .operand_request_valid_i  (request_valid),
    .operand_request_ready_o  (request_ready),
    .operand_queue_ready_i    (queue_ready),
    .vinsn_running_i          (vinsn_running),
    .operand_queue_cmd_o      (queue_cmd),
    .operand_queue_cmd_valid_o(queue_cmd_valid),
    .operand_issued_o         (issued),
    .result_i                 (result),
    .result_gnt_o             (result_gnt),
    .vrf_req_o                (vrf_req),
    .vrf_o                    (vrf)
  );

  bind operand_request_stage operand_request_checker #(
    .NrBanks(NrBanks)
  ) i_operand_request_checker (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .operand_request_valid_i  (operand_request_valid_i),
    .operand_request_ready_o  (operand_request_ready_o),
    .operand_queue_cmd_valid_o(operand_queue_cmd_valid_o),
    .operand_queue_ready_i    (operand_queue_ready_i),
    .operand_issued_o         (operand_issued_o),
    .bank_gnt                 (bank_gnt)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) begin
        lfsr = lfsr ^ 32'hA300_0000;
      end
      r = {r[62:0], lsb};
    end
    return r;
  endfunction

  function automatic operand_request_t rand_cmd();
    operand_request_t c;
    c.vs     = 5'(rand_bits(5));
    c.eew    = vew_e'(rand_bits(2));
    c.vl     = vlen_t'(1 + rand_bits(5));
    c.vstart = vlen_t'(rand_bits(4));
    c.hazard = '0;
    return c;
  endfunction

  // Reference model: one word holds 8 >> eew elements
  function automatic int ref_word_count(input operand_request_t c);
    return ((int'(c.vl) << int'(c.eew)) + 7) / 8;
  endfunction

  function automatic exp_word_t ref_word(input operand_request_t c, input int q, input int i);
    exp_word_t r;
    vaddr_t    a;
    a      = vaddr_t'(int'(c.vs) * VRegWords + (int'(c.vstart) >> (3 - int'(c.eew))) + i);
    r.bank = 8'(a % NrBanks);
    r.addr = vaddr_t'(a / NrBanks);
    r.opq  = opqueue_e'(q);
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic fail_note(input string msg);
    other_errs++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // Compare process, sampled mid-cycle once inputs have settled
  always begin
    @(negedge clk);
    #25;
    if (rst_n) begin
      for (int b = 0; b < NrBanks; b++) begin
        if (vrf_req[b] && vrf[b].wen) begin
          match_write(b);
        end else if (vrf_req[b]) begin
          match_read(b);
        end
      end
    end
  end

  task automatic match_read(input int b);
    exp_word_t e;
    int        q;
    q = int'(vrf[b].opqueue);
    if (q >= NrOperandQueues || exp_rd[q].size() == 0) begin
      fail_note($sformatf("unexpected read on bank %0d for queue %0d", b, q));
    end else begin
      e = exp_rd[q].pop_front();
      check("read bank", 64'(b), 64'(e.bank));
      check("vrf_o.addr", 64'(vrf[b].addr), 64'(e.addr));
      check("vrf_o.be", 64'(vrf[b].be), 64'(0));
    end
  endtask

  task automatic match_write(input int b);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_wr.size(); i++) begin
      if (idx < 0 && exp_wr[i].bank == 8'(b) && exp_wr[i].req.wdata == vrf[b].wdata) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      fail_note($sformatf("unexpected write on bank %0d", b));
    end else begin
      check("vrf_o.addr", 64'(vrf[b].addr), 64'(exp_wr[idx].req.addr));
      check("vrf_o.be", 64'(vrf[b].be), 64'(exp_wr[idx].req.be));
      exp_wr.delete(idx);
    end
  endtask

  // Called right after a falling edge
  task automatic start_cmd(input int q, input operand_request_t c);
    pending_cmd[q]     = c;
    operand_request[q] = c;
    request_valid[q]   = 1'b1;
    for (int i = 0; i < ref_word_count(c); i++) begin
      exp_rd[q].push_back(ref_word(c, q, i));
    end
  endtask

  task automatic accept_cmds(input logic [NrOperandQueues-1:0] mask);
    #10;
    for (int q = 0; q < NrOperandQueues; q++) begin
      if (mask[q]) begin
        check("operand_request_ready_o", 64'(request_ready[q]), 64'(1));
        check("operand_queue_cmd_valid_o", 64'(queue_cmd_valid[q]), 64'(1));
        check("operand_queue_cmd_o.eew", 64'(queue_cmd[q].eew), 64'(pending_cmd[q].eew));
        check("operand_queue_cmd_o.vl", 64'(queue_cmd[q].vl), 64'(pending_cmd[q].vl));
      end
    end
    @(negedge clk);
    request_valid = request_valid & ~mask;
  endtask

  task automatic run_until_done(input bit pause);
    int  cycles;
    int  waits [NrOperandQueues];
    bit  busy;
    cycles = 0;
    busy   = 1'b1;
    for (int q = 0; q < NrOperandQueues; q++) begin
      waits[q] = 0;
    end
    while (busy) begin
      busy = 1'b0;
      for (int q = 0; q < NrOperandQueues; q++) begin
        busy |= exp_rd[q].size() != 0;
      end
      if (busy) begin
        queue_ready = pause ? NrOperandQueues'(rand_bits(NrOperandQueues)) : '1;
        #30;
        check("operand_issued_o while not ready", 64'(issued & ~queue_ready), 64'(0));
        // A read held by a ready queue must win its bank within five cycles
        for (int q = 0; q < NrOperandQueues; q++) begin
          if (queue_ready[q] && !issued[q] && exp_rd[q].size() != 0) begin
            waits[q]++;
            if (waits[q] == 5) begin
              fail_note($sformatf("queue %0d not granted within five cycles", q));
            end
          end else begin
            waits[q] = 0;
          end
        end
        @(negedge clk);
        cycles++;
        if (cycles > MaxWords * 8) begin
          fail_note("reads did not complete");
          busy = 1'b0;
        end
      end
    end
    queue_ready = '1;
  endtask

  task automatic write_word(input int w, input vid_t id, input vaddr_t addr,
                            output int waited);
    exp_write_t e;
    e.bank       = 8'(addr % NrBanks);
    e.req        = '0;
    e.req.addr   = vaddr_t'(addr / NrBanks);
    e.req.wen    = 1'b1;
    e.req.wdata  = rand_bits(64);
    e.req.be     = strb_t'(rand_bits(8));
    exp_wr.push_back(e);
    result[w].req   = 1'b1;
    result[w].id    = id;
    result[w].addr  = addr;
    result[w].wdata = e.req.wdata;
    result[w].be    = e.req.be;
    waited = 0;
    #25;
    while (!result_gnt[w]) begin
      @(negedge clk);
      waited++;
      #25;
    end
    if (waited >= 5) begin
      fail_note($sformatf("writer %0d not granted within five cycles", w));
    end
    @(negedge clk);
    result[w].req = 1'b0;
  endtask

  initial begin
    operand_request_t c;
    vid_t             k;
    int               w0;
    int               w1;
    int               cnt;
    operand_request = '0;
    request_valid   = '0;
    queue_ready     = '1;
    vinsn_running   = '0;
    result          = '0;
    @(posedge rst_n);
    @(negedge clk);
    #25;
    check("operand_request_ready_o", 64'(request_ready), 64'(0));
    check("operand_queue_cmd_valid_o", 64'(queue_cmd_valid), 64'(0));
    check("operand_issued_o", 64'(issued), 64'(0));
    check("vrf_req_o", 64'(vrf_req), 64'(0));
    check("result_gnt_o", 64'(result_gnt), 64'(0));
    @(negedge clk);

    // One command per queue; queues 1 and 2 see random back-pressure
    for (int q = 0; q < NrOperandQueues; q++) begin
      start_cmd(q, rand_cmd());
      accept_cmds(NrOperandQueues'(1 << q));
      run_until_done(q != 0);
    end

    // Two writers on different banks in one cycle
    fork
      write_word(WR_ALU, vid_t'(rand_bits(3)), vaddr_t'(rand_bits(6) * NrBanks), w0);
      write_word(WR_LDU, vid_t'(rand_bits(3)), vaddr_t'(rand_bits(6) * NrBanks + 1), w1);
    join
    check("ALU write wait cycles", 64'(w0), 64'(0));
    check("load write wait cycles", 64'(w1), 64'(0));

    // All readers plus both writers contend for bank 0
    for (int q = 0; q < NrOperandQueues; q++) begin
      start_cmd(q, rand_cmd());
    end
    accept_cmds('1);
    fork
      run_until_done(1'b0);
      repeat (6) begin
        fork
          write_word(WR_ALU, vid_t'(rand_bits(3)), vaddr_t'(rand_bits(6) * NrBanks), w0);
          write_word(WR_LDU, vid_t'(rand_bits(3)), vaddr_t'(rand_bits(6) * NrBanks), w1);
        join
      end
    join

    // Hazard on a running instruction k
    k                = vid_t'(rand_bits(3));
    vinsn_running[k] = 1'b1;
    c                = rand_cmd();
    c.hazard[k]      = 1'b1;
    start_cmd(0, c);
    accept_cmds(3'b001);
    repeat (6) begin
      #30;
      check("operand_issued_o[0] under hazard", 64'(issued[0]), 64'(0));
      @(negedge clk);
    end
    write_word(WR_ALU, k, vaddr_t'(rand_bits(8)), w0);
    // A write of k releases exactly one read
    cnt = 0;
    repeat (4) begin
      #30;
      cnt += int'(issued[0]);
      @(negedge clk);
    end
    check("reads after hazard write", 64'(cnt), 64'(1));
    vinsn_running[k] = 1'b0;
    run_until_done(1'b0);

    repeat (3) @(negedge clk);
    for (int q = 0; q < NrOperandQueues; q++) begin
      if (exp_rd[q].size() != 0) begin
        fail_note($sformatf("queue %0d is missing %0d reads", q, exp_rd[q].size()));
      end
    end
    if (exp_wr.size() != 0) begin
      fail_note($sformatf("%0d writes never reached a bank", exp_wr.size()));
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
verilog/opreq_pkg.sv
verilog/request_decoder.sv
verilog/operand_requester.sv
verilog/result_collector.sv
verilog/bank_arbiter.sv
verilog/operand_request_stage.sv
dv/tb_clock_gen.sv
dv/operand_request_checker.sv
dv/tb_operand_request_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_operand_request_stage
FILELIST  := src.f
FLAGS     := --binary --timing --assert -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
